// ==== verilog/loader_pkg.sv ====
`default_nettype none

package loader_pkg;

	// Host download bus as seen by the core
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [24:0] addr;
		logic [15:0] dout;
		logic [7:0]  index;
	} ioctl_bus_t;

	// One bit per download kind, at most one set at a time
	typedef struct packed {
		logic cart;
		logic palette;
		logic border;
		logic cgb_boot;
		logic dmg_boot;
		logic sgb_boot;
		logic cheat;
	} dl_kind_t;

	// File index codes from the loader menu
	localparam logic [7:0] IDX_PALETTE  = 8'h03;
	localparam logic [7:0] IDX_BORDER   = 8'h02;
	localparam logic [7:0] IDX_CGB_BOOT = 8'h04;
	localparam logic [7:0] IDX_DMG_BOOT = 8'h05;
	localparam logic [7:0] IDX_SGB_BOOT = 8'h06;
	localparam logic [7:0] IDX_CHEAT    = 8'hFF;
	localparam logic [7:0] IDX_MD_CART  = 8'h81;

	// Any cart slot shares these low index bits
	localparam logic [5:0] IDX_CART_LOW = 6'h01;

endpackage

`default_nettype wire

// ==== verilog/core_cfg_pkg.sv ====
`default_nettype none

package core_cfg_pkg;

	// Byte sum of a colour boot image, wraps at 18 bits
	typedef logic [17:0] checksum_t;

	// Known colour boot images
	localparam checksum_t CHECKSUM_CUSTOM_CGB   = 18'h2CE10;
	localparam checksum_t CHECKSUM_ORIGINAL_CGB = 18'h2F3EA;

	// Four 24-bit mono colour sets, low word not used by the LCD
	typedef struct packed {
		logic [23:0] pal1;
		logic [23:0] pal2;
		logic [23:0] pal3;
		logic [23:0] pal4;
		logic [31:0] reserved;
	} palette_t;

	localparam palette_t PALETTE_DEFAULT = 128'h828214517356305A5F1A3B4900000000;

	// Game Genie style code, valid strobes it into the core
	typedef struct packed {
		logic        valid;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic      custom_cgb;
		logic      custom_dmg;
		logic      real_cgb;
		logic      fastboot_available;
		logic      gba_available;
		checksum_t checksum;
	} boot_status_t;

	typedef struct packed {
		logic signed [15:0] left;
		logic signed [15:0] right;
	} audio_pair_t;

endpackage

`default_nettype wire

// ==== verilog/download_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module download_router (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire loader_pkg::ioctl_bus_t ioctl,
	output loader_pkg::ioctl_bus_t bus_q,
	output loader_pkg::dl_kind_t   kind,
	output loader_pkg::dl_kind_t   kind_start
);

	loader_pkg::dl_kind_t kind_d;

	////////////////////////////////////////
	// Index decode
	////////////////////////////////////////

	always_comb begin
		kind_d = '0;
		if (ioctl.download) begin
			// Index 0x80 is the plain cart slot without a system hint
			kind_d.cart     = (ioctl.index[5:0] == loader_pkg::IDX_CART_LOW) ||
				(ioctl.index == 8'h80) || (ioctl.index == loader_pkg::IDX_MD_CART);
			kind_d.palette  = (ioctl.index == loader_pkg::IDX_PALETTE);
			kind_d.border   = (ioctl.index == loader_pkg::IDX_BORDER);
			kind_d.cgb_boot = (ioctl.index == loader_pkg::IDX_CGB_BOOT);
			kind_d.dmg_boot = (ioctl.index == loader_pkg::IDX_DMG_BOOT);
			kind_d.sgb_boot = (ioctl.index == loader_pkg::IDX_SGB_BOOT);
			kind_d.cheat    = (ioctl.index == loader_pkg::IDX_CHEAT);
		end
	end

	////////////////////////////////////////
	// Registered bus and kinds
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bus_q      <= '0;
			kind       <= '0;
			kind_start <= '0;
		end else begin
			bus_q      <= ioctl;
			kind       <= kind_d;
			// kind still holds the previous decode here
			kind_start <= kind_d & ~kind;
		end
	end

	// Units downstream assume a single active kind
	assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(kind))
		else $error("more than one download kind active");

endmodule

`default_nettype wire

// ==== verilog/boot_rom_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_rom_tracker (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire loader_pkg::ioctl_bus_t  bus_q,
	input  wire loader_pkg::dl_kind_t    kind,
	input  wire loader_pkg::dl_kind_t    kind_start,
	input  wire                          is_gbc,
	output core_cfg_pkg::boot_status_t   boot_status
);

	logic                    custom_cgb;
	logic                    custom_dmg;
	core_cfg_pkg::checksum_t checksum;
	logic                    checksum_custom;
	logic                    checksum_original;

	////////////////////////////////////////
	// Sticky replacement flags
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_cgb <= 1'b0;
			custom_dmg <= 1'b0;
		end else begin
			if (kind.cgb_boot)
				custom_cgb <= 1'b1;
			if (kind.dmg_boot)
				custom_dmg <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Colour boot image checksum
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			checksum <= '0;
		end else if (kind_start.cgb_boot) begin
			// New image, start over
			checksum <= '0;
		end else if (kind.cgb_boot && bus_q.wr) begin
			checksum <= checksum
				+ core_cfg_pkg::checksum_t'(bus_q.dout[15:8])
				+ core_cfg_pkg::checksum_t'(bus_q.dout[7:0]);
		end
	end

	assign checksum_custom   = (checksum == core_cfg_pkg::CHECKSUM_CUSTOM_CGB);
	assign checksum_original = (checksum == core_cfg_pkg::CHECKSUM_ORIGINAL_CGB);

	// Derived availability
	always_comb begin
		boot_status.custom_cgb    = custom_cgb;
		boot_status.custom_dmg    = custom_dmg;
		boot_status.checksum      = checksum;
		boot_status.real_cgb      = checksum_original;
		// GBA mode needs a known colour image or the built-in one
		boot_status.gba_available = !custom_cgb || checksum_original || checksum_custom;
		// Unknown custom images may not skip the logo sequence
		boot_status.fastboot_available =
			!((is_gbc && custom_cgb && !checksum_custom) || (!is_gbc && custom_dmg));
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		!kind.cgb_boot |=> $stable(checksum))
		else $error("checksum moved outside a colour boot download");

endmodule

`default_nettype wire

// ==== verilog/palette_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module palette_loader (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire loader_pkg::ioctl_bus_t bus_q,
	input  wire loader_pkg::dl_kind_t   kind,
	output core_cfg_pkg::palette_t      palette
);

	logic [15:0] word_swapped;

	// File stores each colour byte pair big endian
	assign word_swapped = {bus_q.dout[7:0], bus_q.dout[15:8]};

	////////////////////////////////////////
	// Shift register
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= core_cfg_pkg::PALETTE_DEFAULT;
		end else if (kind.palette && bus_q.wr) begin
			// Oldest word falls off the top
			palette <= {palette[111:0], word_swapped};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cheat_code_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module cheat_code_loader (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire loader_pkg::ioctl_bus_t bus_q,
	input  wire loader_pkg::dl_kind_t   kind,
	input  wire loader_pkg::dl_kind_t   kind_start,
	output core_cfg_pkg::cheat_code_t   cheat_code,
	output logic                        cheat_reset
);

	logic code_wr;

	assign code_wr = kind.cheat && bus_q.wr;

	////////////////////////////////////////
	// Word placement
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_code <= '0;
		end else begin
			cheat_code.valid <= 1'b0;
			if (code_wr) begin
				case (bus_q.addr[3:0])
					4'd0:  cheat_code.flags[15:0]    <= bus_q.dout;
					4'd2:  cheat_code.flags[31:16]   <= bus_q.dout;
					4'd4:  cheat_code.address[15:0]  <= bus_q.dout;
					4'd6:  cheat_code.address[31:16] <= bus_q.dout;
					4'd8:  cheat_code.compare[15:0]  <= bus_q.dout;
					4'd10: cheat_code.compare[31:16] <= bus_q.dout;
					4'd12: cheat_code.replace[15:0]  <= bus_q.dout;
					4'd14: begin
						// Last word completes the code
						cheat_code.replace[31:16] <= bus_q.dout;
						cheat_code.valid          <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Clear stored codes on a new cheat file, cart or palette
	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_reset <= 1'b0;
		else
			cheat_reset <= (code_wr && (bus_q.addr == '0)) ||
				kind_start.cart || kind_start.palette;
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		cheat_code.valid |=> !cheat_code.valid)
		else $error("cheat valid held for two cycles");

endmodule

`default_nettype wire

// ==== verilog/fast_forward_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fast_forward_latch #(
	parameter int ff_hold_cycles = 3200000
) (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire                            ff_button,
	input  wire                            download,
	input  wire                            osd_open,
	input  wire                            ff_mute_en,
	input  wire core_cfg_pkg::audio_pair_t audio_in,
	output logic                           fast_forward,
	output core_cfg_pkg::audio_pair_t      audio_out
);

	logic        btn_q;
	logic        btn_last;
	logic [31:0] hold_count;
	logic        ff_latch;
	logic        was_tap;
	logic        short_hold;

	assign short_hold = (hold_count < 32'(ff_hold_cycles));

	////////////////////////////////////////
	// Tap and hold detection
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			btn_q        <= 1'b0;
			btn_last     <= 1'b0;
			hold_count   <= '0;
			ff_latch     <= 1'b0;
			was_tap      <= 1'b0;
			fast_forward <= 1'b0;
		end else begin
			// Button is ignored while loading or in the menu
			btn_q    <= ff_button && !download && !osd_open;
			btn_last <= btn_q;

			// Saturate so a long hold never looks short
			if (btn_q && short_hold)
				hold_count <= hold_count + 32'd1;

			if (btn_q && !btn_last) begin
				ff_latch   <= 1'b0;
				hold_count <= '0;
			end

			if (!btn_q && btn_last) begin
				was_tap <= 1'b0;
				// Second tap in a row leaves the latch clear
				if (short_hold && !was_tap) begin
					was_tap  <= 1'b1;
					ff_latch <= 1'b1;
				end
			end

			fast_forward <= btn_q || ff_latch;
		end
	end

	// Optional mute while running fast
	assign audio_out = (fast_forward && ff_mute_en) ? '0 : audio_in;

endmodule

`default_nettype wire

// ==== verilog/loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module loader_top #(
	parameter int ff_hold_cycles = 3200000
) (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire loader_pkg::ioctl_bus_t    ioctl,
	input  wire                            is_gbc,
	input  wire                            ff_button,
	input  wire                            osd_open,
	input  wire                            ff_mute_en,
	input  wire core_cfg_pkg::audio_pair_t audio_in,
	output core_cfg_pkg::palette_t         palette,
	output core_cfg_pkg::cheat_code_t      cheat_code,
	output logic                           cheat_reset,
	output core_cfg_pkg::boot_status_t     boot_status,
	output logic                           fast_forward,
	output core_cfg_pkg::audio_pair_t      audio_out
);

	loader_pkg::ioctl_bus_t bus_q;
	loader_pkg::dl_kind_t   kind;
	loader_pkg::dl_kind_t   kind_start;

	////////////////////////////////////////
	// Download path
	////////////////////////////////////////

	download_router download_router_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ioctl      (ioctl),
		.bus_q      (bus_q),
		.kind       (kind),
		.kind_start (kind_start)
	);

	boot_rom_tracker boot_rom_tracker_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus_q       (bus_q),
		.kind        (kind),
		.kind_start  (kind_start),
		.is_gbc      (is_gbc),
		.boot_status (boot_status)
	);

	palette_loader palette_loader_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus_q   (bus_q),
		.kind    (kind),
		.palette (palette)
	);

	cheat_code_loader cheat_code_loader_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus_q       (bus_q),
		.kind        (kind),
		.kind_start  (kind_start),
		.cheat_code  (cheat_code),
		.cheat_reset (cheat_reset)
	);

	////////////////////////////////////////
	// Fast-forward
	////////////////////////////////////////

	// Raw download level, not the registered copy
	fast_forward_latch #(
		.ff_hold_cycles (ff_hold_cycles)
	) fast_forward_latch_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ff_button    (ff_button),
		.download     (ioctl.download),
		.osd_open     (osd_open),
		.ff_mute_en   (ff_mute_en),
		.audio_in     (audio_in),
		.fast_forward (fast_forward),
		.audio_out    (audio_out)
	);

endmodule

`default_nettype wire

// ==== verif/tb_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_loader_top;

	localparam int FF_HOLD   = 40;
	localparam int NUM_TESTS = 11;

	localparam logic [3:0] OP_RESET      = 4'd0;
	localparam logic [3:0] OP_PALETTE    = 4'd1;
	localparam logic [3:0] OP_CHEAT      = 4'd2;
	localparam logic [3:0] OP_CGB_RANDOM = 4'd3;
	localparam logic [3:0] OP_CGB_CRAFT  = 4'd4;
	localparam logic [3:0] OP_DMG        = 4'd5;
	localparam logic [3:0] OP_BUTTON     = 4'd6;
	localparam logic [3:0] OP_OSD        = 4'd7;
	localparam logic [3:0] OP_AUDIO      = 4'd8;

	// Expected flags are {fast_forward, fastboot_available, gba_available, real_cgb}
	typedef struct packed {
		logic [3:0]  op;
		logic [7:0]  index;
		logic [15:0] count;
		logic        gbc;
		logic [3:0]  exp_flags;
	} test_entry_t;

	logic                       clk_sys;
	logic                       reset;
	loader_pkg::ioctl_bus_t     ioctl;
	logic                       is_gbc;
	logic                       ff_button;
	logic                       osd_open;
	logic                       ff_mute_en;
	core_cfg_pkg::audio_pair_t  audio_in;
	core_cfg_pkg::palette_t     palette;
	core_cfg_pkg::cheat_code_t  cheat_code;
	logic                       cheat_reset;
	core_cfg_pkg::boot_status_t boot_status;
	logic                       fast_forward;
	core_cfg_pkg::audio_pair_t  audio_out;

	test_entry_t            tests [NUM_TESTS];
	logic [31:0]            lfsr_state;
	core_cfg_pkg::palette_t pal_exp;
	int                     valid_count = 0;
	int                     reset_count = 0;
	int                     test_errors;
	int                     pass_count = 0;
	int                     fail_count = 0;
	int                     t;

	loader_top #(
		.ff_hold_cycles (FF_HOLD)
	) loader_top_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ioctl        (ioctl),
		.is_gbc       (is_gbc),
		.ff_button    (ff_button),
		.osd_open     (osd_open),
		.ff_mute_en   (ff_mute_en),
		.audio_in     (audio_in),
		.palette      (palette),
		.cheat_code   (cheat_code),
		.cheat_reset  (cheat_reset),
		.boot_status  (boot_status),
		.fast_forward (fast_forward),
		.audio_out    (audio_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// One-cycle pulses are seen by exactly one falling edge
	always @(negedge clk_sys) begin
		if (cheat_code.valid)
			valid_count++;
		if (cheat_reset)
			reset_count++;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Galois LFSR, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		int          i;
		val = '0;
		for (i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return val;
	endfunction

	function automatic test_entry_t make_entry(input logic [3:0] op, input logic [7:0] index,
		input logic [15:0] count, input logic gbc, input logic [3:0] exp_flags);
		return {op, index, count, gbc, exp_flags};
	endfunction

	function automatic string op_name(input logic [3:0] op);
		case (op)
			OP_RESET:      return "reset values";
			OP_PALETTE:    return "palette download";
			OP_CHEAT:      return "cheat code";
			OP_CGB_RANDOM: return "colour boot checksum";
			OP_CGB_CRAFT:  return "original colour boot";
			OP_DMG:        return "mono boot";
			OP_BUTTON:     return "fast-forward button";
			OP_OSD:        return "button with OSD open";
			default:       return "audio mute";
		endcase
	endfunction

	task automatic report_error(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		test_errors++;
	endtask

	task automatic start_download(input logic [7:0] index);
		@(negedge clk_sys);
		ioctl.index    = index;
		ioctl.download = 1'b1;
		ioctl.wr       = 1'b0;
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		ioctl.addr = addr;
		ioctl.dout = data;
		ioctl.wr   = 1'b1;
		@(negedge clk_sys);
		ioctl.wr   = 1'b0;
	endtask

	task automatic end_download;
		@(negedge clk_sys);
		ioctl.download = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic check_boot_flags(input logic [3:0] exp_flags);
		if (boot_status.fastboot_available !== exp_flags[2])
			report_error($sformatf("fastboot_available is %b", boot_status.fastboot_available));
		if (boot_status.gba_available !== exp_flags[1])
			report_error($sformatf("gba_available is %b", boot_status.gba_available));
		if (boot_status.real_cgb !== exp_flags[0])
			report_error($sformatf("real_cgb is %b", boot_status.real_cgb));
	endtask

	// Press for a number of cycles, then check the settled state
	task automatic hold_button(input int cycles, input logic exp_after);
		int i;
		@(negedge clk_sys);
		ff_button = 1'b1;
		for (i = 0; i < cycles; i++) begin
			@(negedge clk_sys);
			if (i >= 2 && fast_forward !== !osd_open)
				report_error("fast_forward wrong while the button is held");
		end
		ff_button = 1'b0;
		repeat (4) @(negedge clk_sys);
		if (fast_forward !== exp_after)
			report_error($sformatf("fast_forward is %b after release", fast_forward));
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic run_palette(input test_entry_t e);
		int          i;
		int          resets_before;
		logic [15:0] w;
		resets_before = reset_count;
		start_download(e.index);
		for (i = 0; i < e.count; i++) begin
			w = 16'(take_bits(16));
			pal_exp = {pal_exp[111:0], w[7:0], w[15:8]};
			write_word(25'(i * 2), w);
		end
		end_download();
		if (palette !== pal_exp)
			report_error($sformatf("palette %h expected %h", palette, pal_exp));
		if (reset_count - resets_before != 1)
			report_error("cheat_reset did not pulse once at palette start");
	endtask

	task automatic run_cheat(input test_entry_t e);
		int          i;
		int          waited;
		int          valid_before;
		int          resets_before;
		logic [15:0] words [8];
		valid_before  = valid_count;
		resets_before = reset_count;
		start_download(e.index);
		for (i = 0; i < 8; i++) begin
			words[i] = 16'(take_bits(16));
			write_word(25'(i * 2), words[i]);
		end
		end_download();
		waited = 0;
		while (valid_count == valid_before && waited < 20) begin
			@(negedge clk_sys);
			waited++;
		end
		if (valid_count == valid_before) begin
			$display("Timed out waiting for the cheat code valid pulse");
			test_errors++;
		end
		repeat (3) @(negedge clk_sys);
		if (valid_count - valid_before > 1)
			report_error("cheat valid pulsed more than once");
		if (reset_count - resets_before != 1)
			report_error("cheat_reset did not pulse once for address 0");
		if (cheat_code.flags !== {words[1], words[0]})
			report_error($sformatf("cheat flags %h", cheat_code.flags));
		if (cheat_code.address !== {words[3], words[2]})
			report_error($sformatf("cheat address %h", cheat_code.address));
		if (cheat_code.compare !== {words[5], words[4]})
			report_error($sformatf("cheat compare %h", cheat_code.compare));
		if (cheat_code.replace !== {words[7], words[6]})
			report_error($sformatf("cheat replace %h", cheat_code.replace));
	endtask

	task automatic run_boot(input test_entry_t e);
		int          i;
		int          byte_sum;
		int          remaining;
		logic [17:0] chk;
		logic [15:0] w;
		logic [3:0]  exp_flags;
		byte_sum = 0;
		start_download(e.index);
		if (e.op == OP_CGB_CRAFT) begin
			// Full words first, then split the rest over two bytes
			remaining = int'(core_cfg_pkg::CHECKSUM_ORIGINAL_CGB);
			i = 0;
			while (remaining > 0) begin
				if (remaining >= 510)
					w = 16'hFFFF;
				else
					w = {8'(remaining / 2), 8'(remaining - remaining / 2)};
				remaining = remaining - int'(w[15:8]) - int'(w[7:0]);
				byte_sum  = byte_sum + int'(w[15:8]) + int'(w[7:0]);
				write_word(25'(i * 2), w);
				i++;
			end
		end else begin
			for (i = 0; i < e.count; i++) begin
				w = 16'(take_bits(16));
				byte_sum = byte_sum + int'(w[15:8]) + int'(w[7:0]);
				write_word(25'(i * 2), w);
			end
		end
		end_download();
		exp_flags = e.exp_flags;
		if (e.op == OP_DMG) begin
			if (boot_status.custom_dmg !== 1'b1)
				report_error("custom_dmg not set");
		end else begin
			chk = 18'(byte_sum % (1 << 18));
			if (boot_status.checksum !== chk)
				report_error($sformatf("checksum %h expected %h", boot_status.checksum, chk));
			if (boot_status.custom_cgb !== 1'b1)
				report_error("custom_cgb not set");
			if (e.op == OP_CGB_RANDOM) begin
				exp_flags[2] = (chk == core_cfg_pkg::CHECKSUM_CUSTOM_CGB);
				exp_flags[0] = (chk == core_cfg_pkg::CHECKSUM_ORIGINAL_CGB);
				exp_flags[1] = exp_flags[2] || exp_flags[0];
			end
		end
		check_boot_flags(exp_flags);
	endtask

	task automatic run_audio(input test_entry_t e);
		int                        i;
		core_cfg_pkg::audio_pair_t exp_audio;
		// A tap leaves fast-forward running
		hold_button(10, 1'b1);
		for (i = 0; i < e.count; i++) begin
			@(negedge clk_sys);
			audio_in   = take_bits(32);
			ff_mute_en = 1'(take_bits(1));
			#1;
			exp_audio = ff_mute_en ? '0 : audio_in;
			if (audio_out !== exp_audio)
				report_error($sformatf("audio_out %h expected %h", audio_out, exp_audio));
		end
		hold_button(10, 1'b0);
		for (i = 0; i < e.count; i++) begin
			@(negedge clk_sys);
			audio_in   = take_bits(32);
			ff_mute_en = 1'b1;
			#1;
			if (audio_out !== audio_in)
				report_error($sformatf("audio_out %h muted at normal speed", audio_out));
		end
		ff_mute_en = 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		reset      = 1'b1;
		ioctl      = '0;
		is_gbc     = 1'b0;
		ff_button  = 1'b0;
		osd_open   = 1'b0;
		ff_mute_en = 1'b0;
		audio_in   = '0;
		lfsr_state = 32'h77802b40;
		pal_exp    = core_cfg_pkg::PALETTE_DEFAULT;

		tests[0]  = make_entry(OP_RESET, 8'h00, 16'd0, 1'b0, 4'b0110);
		tests[1]  = make_entry(OP_PALETTE, loader_pkg::IDX_PALETTE, 16'd6, 1'b0, 4'b0000);
		tests[2]  = make_entry(OP_CHEAT, loader_pkg::IDX_CHEAT, 16'd8, 1'b0, 4'b0000);
		tests[3]  = make_entry(OP_CGB_RANDOM, loader_pkg::IDX_CGB_BOOT, 16'd48, 1'b1, 4'b0000);
		tests[4]  = make_entry(OP_CGB_CRAFT, loader_pkg::IDX_CGB_BOOT, 16'd0, 1'b1, 4'b0011);
		tests[5]  = make_entry(OP_DMG, loader_pkg::IDX_DMG_BOOT, 16'd16, 1'b0, 4'b0011);
		tests[6]  = make_entry(OP_BUTTON, 8'h00, 16'd10, 1'b0, 4'b1000);
		tests[7]  = make_entry(OP_BUTTON, 8'h00, 16'd10, 1'b0, 4'b0000);
		tests[8]  = make_entry(OP_BUTTON, 8'h00, 16'd60, 1'b0, 4'b0000);
		tests[9]  = make_entry(OP_OSD, 8'h00, 16'd20, 1'b0, 4'b0000);
		tests[10] = make_entry(OP_AUDIO, 8'h00, 16'd8, 1'b0, 4'b0000);

		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		for (t = 0; t < NUM_TESTS; t++) begin
			test_errors = 0;
			is_gbc = tests[t].gbc;
			@(negedge clk_sys);
			case (tests[t].op)
				OP_RESET: begin
					if (palette !== core_cfg_pkg::PALETTE_DEFAULT)
						report_error($sformatf("palette %h after reset", palette));
					if (cheat_code !== '0 || cheat_reset !== 1'b0)
						report_error("cheat outputs not clear after reset");
					if (fast_forward !== 1'b0)
						report_error("fast_forward set after reset");
					if (boot_status.checksum !== '0)
						report_error("checksum not clear after reset");
					check_boot_flags(tests[t].exp_flags);
				end
				OP_PALETTE: run_palette(tests[t]);
				OP_CHEAT:   run_cheat(tests[t]);
				OP_BUTTON:  hold_button(tests[t].count, tests[t].exp_flags[3]);
				OP_OSD: begin
					osd_open = 1'b1;
					hold_button(tests[t].count, tests[t].exp_flags[3]);
					osd_open = 1'b0;
				end
				OP_AUDIO:   run_audio(tests[t]);
				default:    run_boot(tests[t]);
			endcase
			if (test_errors == 0) begin
				pass_count++;
				$display("Test %0d %s: PASS", t, op_name(tests[t].op));
			end else begin
				fail_count++;
				$display("Test %0d %s: FAIL with %0d errors", t, op_name(tests[t].op),
					test_errors);
			end
		end

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/loader_pkg.sv
verilog/core_cfg_pkg.sv
verilog/download_router.sv
verilog/boot_rom_tracker.sv
verilog/palette_loader.sv
verilog/cheat_code_loader.sv
verilog/fast_forward_latch.sv
verilog/loader_top.sv
verif/tb_loader_top.sv

// ==== Bender.yml ====
package:
  name: loader_top

sources:
  - files:
      - verilog/loader_pkg.sv
      - verilog/core_cfg_pkg.sv
      - verilog/download_router.sv
      - verilog/boot_rom_tracker.sv
      - verilog/palette_loader.sv
      - verilog/cheat_code_loader.sv
      - verilog/fast_forward_latch.sv
      - verilog/loader_top.sv
  - target: test
    files:
      - verif/tb_loader_top.sv
